/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mio_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
logic/mio_pkg.sv
logic/mio_tx.sv
logic/mio_rx.sv
logic/mio_regs.sv
logic/mio_dut.sv
verif/mio_checker.sv
verif/mio_tb.sv

/* logic/mio_dut.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_dut #(
   parameter  int AW   = mio_pkg::AW_DEF,
   parameter  int NMIO = mio_pkg::NMIO_DEF,
   parameter  logic [mio_pkg::CFG_W-1:0]    DEF_CFG = mio_pkg::DEF_CFG_DEF,
   parameter  logic [mio_pkg::CLKDIV_W-1:0] DEF_CLK = mio_pkg::DEF_CLK_DEF,
   localparam int PW   = mio_pkg::pw_of(AW)
) (
   // Clock and reset
   input  wire          clk1,
   input  wire          reset,
   output wire          dut_active,
   output wire          clkout,
   // Stimulus side
   input  wire          access_in,
   input  wire [PW-1:0] packet_in,
   output wire          wait_out,
   // Loopback output
   output wire          access_out,
   output wire [PW-1:0] packet_out,
   input  wire          wait_in,
   // Register responses
   output wire          reg_access_out,
   output wire [PW-1:0] reg_packet_out
);

   import mio_pkg::*;

   wire                decode_hit;   // Upper address bits nonzero
   wire                mio_access;
   wire                reg_access;
   wire                tx_access;
   wire [NMIO-1:0]     tx_packet;
   wire                rx_wait;
   wire                rx_done;
   wire                cfg_tx_en;
   wire [CLKDIV_W-1:0] clk_div;

   assign dut_active = 1'b1;
   assign clkout     = clk1;

   //##########################################################################
   // Address decode
   //##########################################################################

   assign decode_hit = |packet_in[DECODE_MSB:DECODE_LSB];
   assign mio_access = access_in & decode_hit;     // To the link
   assign reg_access = access_in & ~decode_hit;    // To the register file

   //##########################################################################
   // Link in loopback
   //##########################################################################

   mio_tx #(.AW(AW), .NMIO(NMIO)) u_mio_tx (
      .clk       (clk1),
      .reset     (reset),
      .access_in (mio_access),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .cfg_tx_en (cfg_tx_en),
      .clk_div   (clk_div),
      .rx_wait   (rx_wait),
      .tx_access (tx_access),
      .tx_packet (tx_packet)
   );

   mio_rx #(.AW(AW), .NMIO(NMIO)) u_mio_rx (
      .clk        (clk1),
      .reset      (reset),
      .rx_access  (tx_access),                     // Beats straight back
      .rx_packet  (tx_packet),
      .rx_wait    (rx_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .rx_done    (rx_done)
   );

   // Config, divider and status
   mio_regs #(.AW(AW), .DEF_CFG(DEF_CFG), .DEF_CLK(DEF_CLK)) u_mio_regs (
      .clk            (clk1),
      .reset          (reset),
      .reg_access_in  (reg_access),
      .reg_packet_in  (packet_in),
      .rx_done        (rx_done),
      .cfg_tx_en      (cfg_tx_en),
      .clk_div        (clk_div),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_packet_out),
      .wait_in        (wait_in)
   );

endmodule

`default_nettype wire

/* logic/mio_pkg.sv */
`default_nettype none

package mio_pkg;

   //##########################################################################
   // Widths and defaults
   //##########################################################################

   localparam int AW_DEF   = 32;          // Address width
   localparam int NMIO_DEF = 8;           // IO lane width

   // Emesh packet width from address width
   function automatic int pw_of(input int aw);
      return 2*aw + 40;
   endfunction

   localparam int PW_DEF = pw_of(AW_DEF); // 104 for 32 bit addresses

   //##########################################################################
   // Packet layout
   //##########################################################################

   localparam int PKT_WRITE       = 0;    // Write flag
   localparam int PKT_DSTADDR_LSB = 8;    // Destination address
   localparam int PKT_DATA_LSB    = 40;   // Data word
   localparam int PKT_SRCADDR_LSB = 72;   // Source address

   // Decode field, address bits 31..20
   localparam int DECODE_MSB = 39;
   localparam int DECODE_LSB = 28;

   //##########################################################################
   // Register map
   //##########################################################################

   // Register index from address bits 3..2
   localparam int REG_IDX_LSB = PKT_DSTADDR_LSB + 2;
   localparam int REG_IDX_MSB = PKT_DSTADDR_LSB + 3;

   localparam logic [1:0] REG_CFG    = 2'd0;   // Link configuration
   localparam logic [1:0] REG_CLKDIV = 2'd1;   // Beat divider
   localparam logic [1:0] REG_STATUS = 2'd2;   // Delivered count, read only

   localparam int CFG_W    = 18;
   localparam int CLKDIV_W = 8;
   localparam int STATUS_W = 16;

   // Config fields
   localparam int CFG_TX_EN = 12;         // Transmitter enable

   localparam logic [CFG_W-1:0]    DEF_CFG_DEF = 18'h1070;  // TX enabled
   localparam logic [CLKDIV_W-1:0] DEF_CLK_DEF = 8'd7;

endpackage

`default_nettype wire

/* logic/mio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_regs #(
   parameter  int AW = mio_pkg::AW_DEF,
   parameter  logic [mio_pkg::CFG_W-1:0]    DEF_CFG = mio_pkg::DEF_CFG_DEF,
   parameter  logic [mio_pkg::CLKDIV_W-1:0] DEF_CLK = mio_pkg::DEF_CLK_DEF,
   localparam int PW = mio_pkg::pw_of(AW),
   localparam int DW = mio_pkg::CLKDIV_W
) (
   input  wire           clk,
   input  wire           reset,
   // Request side
   input  wire           reg_access_in,
   input  wire [PW-1:0]  reg_packet_in,
   // Delivery pulse from receiver
   input  wire           rx_done,
   // Control outputs
   output logic          cfg_tx_en,
   output logic [DW-1:0] clk_div,
   // Response side
   output logic          reg_access_out,
   output logic [PW-1:0] reg_packet_out,
   input  wire           wait_in
);

   import mio_pkg::*;

   logic [CFG_W-1:0]    cfg_q;
   logic [STATUS_W-1:0] status_q;    // Delivered packets
   logic [1:0]          reg_idx;
   logic [AW-1:0]       wr_data;
   logic [AW-1:0]       req_dst;
   logic [AW-1:0]       req_src;
   logic [AW-1:0]       rd_data;
   logic [PW-1:0]       resp_pkt;
   logic                held;
   logic                wr_en;
   logic                rd_en;

   //##########################################################################
   // Request decode
   //##########################################################################

   assign reg_idx = reg_packet_in[REG_IDX_MSB:REG_IDX_LSB];
   assign wr_data = reg_packet_in[PKT_DATA_LSB +: AW];
   assign req_dst = reg_packet_in[PKT_DSTADDR_LSB +: AW];
   assign req_src = reg_packet_in[PKT_SRCADDR_LSB +: AW];

   assign held  = reg_access_out & wait_in;        // Response still pending
   assign wr_en = reg_access_in & reg_packet_in[PKT_WRITE];
   assign rd_en = reg_access_in & ~reg_packet_in[PKT_WRITE] & ~held;

   // Read mux
   always_comb begin
      case (reg_idx)
         REG_CFG:    rd_data = AW'(cfg_q);
         REG_CLKDIV: rd_data = AW'(clk_div);
         REG_STATUS: rd_data = AW'(status_q);
         default:    rd_data = '0;
      endcase
   end

   // Response with addresses swapped
   always_comb begin
      resp_pkt                              = '0;
      resp_pkt[PKT_WRITE]                   = 1'b1;
      resp_pkt[PKT_DSTADDR_LSB +: AW]       = req_src;
      resp_pkt[PKT_DATA_LSB +: AW]          = rd_data;
      resp_pkt[PKT_SRCADDR_LSB +: AW]       = req_dst;
   end

   //##########################################################################
   // Registers
   //##########################################################################

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_q   <= DEF_CFG;
         clk_div <= DEF_CLK;
      end else if (wr_en) begin
         case (reg_idx)
            REG_CFG:    cfg_q   <= wr_data[CFG_W-1:0];   // Truncated
            REG_CLKDIV: clk_div <= wr_data[DW-1:0];
            default: ;                                   // STATUS ignores writes
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         status_q <= '0;
      end else if (rx_done) begin
         status_q <= status_q + 1'b1;
      end
   end

   assign cfg_tx_en = cfg_q[CFG_TX_EN];

   // Response valid, next cycle after the read
   always_ff @(posedge clk) begin
      if (reset) begin
         reg_access_out <= 1'b0;
      end else if (rd_en) begin
         reg_access_out <= 1'b1;
      end else if (!wait_in) begin
         reg_access_out <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         reg_packet_out <= resp_pkt;
      end
   end

endmodule

`default_nettype wire

/* logic/mio_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_rx #(
   parameter  int AW   = mio_pkg::AW_DEF,
   parameter  int NMIO = mio_pkg::NMIO_DEF,
   localparam int PW   = mio_pkg::pw_of(AW)
) (
   input  wire            clk,
   input  wire            reset,
   // Beat side
   input  wire            rx_access,
   input  wire [NMIO-1:0] rx_packet,
   output logic           rx_wait,
   // Packet side
   output logic           access_out,
   output logic [PW-1:0]  packet_out,
   input  wire            wait_in,
   // Delivery pulse for status counter
   output logic           rx_done
);

   localparam int NBEATS = (PW + NMIO - 1) / NMIO;   // Beats per packet
   localparam int SW     = NBEATS * NMIO;
   localparam int BCW    = $clog2(NBEATS + 1);

   logic [SW-1:0]  asm_q;       // Assembly register
   logic [SW-1:0]  asm_next;
   logic [BCW-1:0] beat_cnt;
   logic           last_beat;   // Next beat completes a packet
   logic           complete;

   //##########################################################################
   // Assembly
   //##########################################################################

   // New beat enters at the top, first beat ends at the bottom
   assign asm_next  = (asm_q >> NMIO) | (SW'(rx_packet) << (SW - NMIO));
   assign last_beat = (beat_cnt == BCW'(NBEATS - 1));
   assign complete  = rx_access & last_beat;

   // Only the final beat is held back, earlier ones overlap the held output
   assign rx_wait   = access_out & last_beat;
   assign rx_done   = access_out & ~wait_in;       // Packet taken this cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_cnt   <= '0;
         access_out <= 1'b0;
      end else begin
         if (rx_access) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
         end
         if (complete) begin
            access_out <= 1'b1;                    // Cycle after last beat
         end else if (!wait_in) begin
            access_out <= 1'b0;
         end
      end
   end

   //##########################################################################
   // Payload
   //##########################################################################

   always_ff @(posedge clk) begin
      if (rx_access) begin
         asm_q <= asm_next;
      end
      if (complete) begin
         packet_out <= asm_next[PW-1:0];           // Drop pad bits
      end
   end

endmodule

`default_nettype wire

/* logic/mio_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_tx #(
   parameter  int AW   = mio_pkg::AW_DEF,
   parameter  int NMIO = mio_pkg::NMIO_DEF,
   localparam int PW   = mio_pkg::pw_of(AW),
   localparam int DW   = mio_pkg::CLKDIV_W
) (
   input  wire            clk,
   input  wire            reset,
   // Packet side
   input  wire            access_in,
   input  wire [PW-1:0]   packet_in,
   output logic           wait_out,
   // Control from register file
   input  wire            cfg_tx_en,
   input  wire [DW-1:0]   clk_div,
   // Beat side
   input  wire            rx_wait,
   output logic           tx_access,
   output logic [NMIO-1:0] tx_packet
);

   localparam int NBEATS = (PW + NMIO - 1) / NMIO;   // Beats per packet
   localparam int SW     = NBEATS * NMIO;            // Padded shift width
   localparam int BCW    = $clog2(NBEATS + 1);

   logic [SW-1:0]  shift_q;     // Outgoing packet, lowest beat first
   logic [BCW-1:0] beat_cnt;
   logic [DW-1:0]  div_cnt;     // Beat pacing
   logic           busy;
   logic           accept;
   logic           tick;
   logic           beat;
   logic           last_beat;

   //##########################################################################
   // Beat strobe
   //##########################################################################

   assign accept    = access_in & ~wait_out;
   assign tick      = (div_cnt >= clk_div);        // Divider period reached
   assign beat      = busy & tick & ~rx_wait;      // Receiver can freeze us
   assign last_beat = (beat_cnt == BCW'(NBEATS - 1));

   assign wait_out  = busy | ~cfg_tx_en;           // Closed while disabled
   assign tx_access = beat;
   assign tx_packet = shift_q[NMIO-1:0];

   // Control state
   always_ff @(posedge clk) begin
      if (reset) begin
         busy     <= 1'b0;
         beat_cnt <= '0;
         div_cnt  <= '0;
      end else if (accept) begin
         busy     <= 1'b1;
         beat_cnt <= '0;
         div_cnt  <= '0;                           // Fresh divider period
      end else if (beat) begin
         beat_cnt <= beat_cnt + 1'b1;
         div_cnt  <= '0;
         if (last_beat) begin
            busy <= 1'b0;                          // Partial beat gone too
         end
      end else if (busy && !tick) begin
         div_cnt <= div_cnt + 1'b1;
      end
      // Holding at tick while rx_wait is high
   end

   //##########################################################################
   // Shift register
   //##########################################################################

   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= SW'(packet_in);                // Zero pad above PW
      end else if (beat) begin
         shift_q <= shift_q >> NMIO;               // Next beat to bottom
      end
   end

endmodule

`default_nettype wire

/* verif/mio_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_checker #(
   parameter int PW = mio_pkg::pw_of(mio_pkg::AW_DEF)
) (
   input wire          clk,
   input wire          reset,
   input wire          access_out,
   input wire          wait_in,
   input wire [PW-1:0] packet_out,
   input wire          wait_out,
   input wire          cfg_tx_en,
   input wire          tx_access,
   input wire          rx_wait
);

   // Held packet frozen under wait_in
   a_hold_stable: assert property (@(posedge clk) disable iff (reset)
      access_out && wait_in |=> $stable(packet_out))
      else $error("packet_out changed while held under wait_in");

   a_tx_closed: assert property (@(posedge clk) disable iff (reset)
      !cfg_tx_en |-> wait_out)                     // Disabled link accepts nothing
      else $error("wait_out low with transmitter disabled");

   // Receiver back-pressure stops beats
   a_beat_frozen: assert property (@(posedge clk) disable iff (reset)
      rx_wait |-> !tx_access)
      else $error("beat issued while rx_wait high");

endmodule

bind mio_dut mio_checker #(.PW(PW)) u_mio_checker (
   .clk        (clk1),
   .reset      (reset),
   .access_out (access_out),
   .wait_in    (wait_in),
   .packet_out (packet_out),
   .wait_out   (wait_out),
   .cfg_tx_en  (cfg_tx_en),
   .tx_access  (tx_access),
   .rx_wait    (rx_wait)
);

`default_nettype wire

/* verif/mio_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mio_tb;

   import mio_pkg::*;

   localparam int AW      = AW_DEF;
   localparam int NMIO    = NMIO_DEF;
   localparam int PW      = pw_of(AW);
   localparam logic [CFG_W-1:0]    DEF_CFG = 18'h1070;   // TX enable set
   localparam logic [CLKDIV_W-1:0] DEF_CLK = 8'd7;
   localparam logic [31:0] SEED    = 32'h59d9;
   localparam int TIMEOUT = 5000;                         // Cycles per wait
   localparam int WINDOW  = 300;                          // Disabled watch
   localparam int N_BASIC = 40;
   localparam int N_ROUND = 10;

   logic                clk;
   logic                reset;
   logic                access_in;
   logic [PW-1:0]       packet_in;
   logic                wait_in;
   wire                 dut_active;
   wire                 clkout;
   wire                 wait_out;
   wire                 access_out;
   wire [PW-1:0]        packet_out;
   wire                 reg_access_out;
   wire [PW-1:0]        reg_packet_out;

   logic [31:0]         seed;
   logic [31:0]         bp_state;      // Back-pressure stream
   logic                bp_en;
   logic [CFG_W-1:0]    cfg_m;         // Register model
   logic [CLKDIV_W-1:0] clk_m;
   int                  sent;
   logic [PW-1:0]       expect_q[$];   // Loopback packets in flight
   logic [PW-1:0]       mon_exp;

   mio_dut #(.AW(AW), .NMIO(NMIO), .DEF_CFG(DEF_CFG), .DEF_CLK(DEF_CLK)) u_mio_dut (
      .clk1           (clk),
      .reset          (reset),
      .dut_active     (dut_active),
      .clkout         (clkout),
      .access_in      (access_in),
      .packet_in      (packet_in),
      .wait_out       (wait_out),
      .access_out     (access_out),
      .packet_out     (packet_out),
      .wait_in        (wait_in),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_packet_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                // 20 ns period
   end

   //##########################################################################
   // Helpers
   //##########################################################################

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Emesh packet from its fields
   function automatic logic [PW-1:0] make_pkt(input logic wr, input logic [AW-1:0] dst,
                                              input logic [AW-1:0] data,
                                              input logic [AW-1:0] src);
      logic [PW-1:0] p;
      p                        = '0;
      p[PKT_WRITE]             = wr;
      p[PKT_DSTADDR_LSB +: AW] = dst;
      p[PKT_DATA_LSB +: AW]    = data;
      p[PKT_SRCADDR_LSB +: AW] = src;
      return p;
   endfunction

   // Expected register contents, zero extended
   function automatic logic [31:0] model_read(input logic [1:0] idx);
      case (idx)
         REG_CFG:    return 32'(cfg_m);
         REG_CLKDIV: return 32'(clk_m);
         REG_STATUS: return {16'h0000, sent[15:0]};   // All sent are delivered
         default:    return 32'h0;
      endcase
   endfunction

   task automatic check(input string what, input logic [PW-1:0] got,
                        input logic [PW-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("No progress after %0d cycles while waiting for %s", TIMEOUT, what);
      $display("Test FAILED");
      $fatal(1, "wait timed out");
   endtask

   // Random link packet, decode field nonzero
   task automatic rand_link(output logic [PW-1:0] p);
      logic [127:0] bits;
      seed         = lcg(seed);
      bits[31:0]   = seed;
      seed         = lcg(seed);
      bits[63:32]  = seed;
      seed         = lcg(seed);
      bits[95:64]  = seed;
      seed         = lcg(seed);
      bits[127:96] = seed;
      p            = bits[PW-1:0];
      if (p[DECODE_MSB:DECODE_LSB] == '0) begin
         p[DECODE_LSB] = 1'b1;               // Keep it off the register path
      end
   endtask

   // All stimulus tasks start and end on a falling edge
   task automatic write_reg(input logic [1:0] idx, input logic [31:0] data);
      logic [31:0] src;
      logic [31:0] dst;
      seed      = lcg(seed);
      src       = seed;
      seed      = lcg(seed);
      dst       = {12'h000, seed[31:16], idx, 2'b00};   // Decode bits zero
      access_in = 1'b1;
      packet_in = make_pkt(1'b1, dst, data, src);
      @(negedge clk);
      access_in = 1'b0;
      case (idx)
         REG_CFG:    cfg_m = data[CFG_W-1:0];
         REG_CLKDIV: clk_m = data[CLKDIV_W-1:0];
         default: ;                          // STATUS and spare stay
      endcase
   endtask

   task automatic read_reg(input logic [1:0] idx);
      logic [31:0] src;
      logic [31:0] dst;
      int          cnt;
      seed      = lcg(seed);
      src       = seed;
      seed      = lcg(seed);
      dst       = {12'h000, seed[31:16], idx, 2'b00};
      access_in = 1'b1;
      packet_in = make_pkt(1'b0, dst, 32'h0, src);
      @(negedge clk);
      access_in = 1'b0;
      cnt       = 0;
      while (!reg_access_out) begin
         if (cnt >= TIMEOUT) timeout_fail("a register read response");
         @(negedge clk);
         cnt++;
      end
      // Response due one cycle after the request
      check("register read latency", PW'(cnt), '0);
      // Write flag set, addresses swapped
      check("register read response", reg_packet_out,
            make_pkt(1'b1, src, model_read(idx), dst));
      @(negedge clk);
   endtask

   task automatic send_link(input logic [PW-1:0] p);
      int cnt;
      access_in = 1'b1;
      packet_in = p;
      cnt       = 0;
      while (wait_out) begin                 // Taken on the next rising edge once low
         if (cnt >= TIMEOUT) timeout_fail("wait_out to drop");
         @(negedge clk);
         cnt++;
      end
      expect_q.push_back(p);
      sent++;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic wait_drain(input string what);
      int cnt;
      cnt = 0;
      while (expect_q.size() > 0) begin
         if (cnt >= TIMEOUT) timeout_fail(what);
         @(negedge clk);
         cnt++;
      end
   endtask

   //##########################################################################
   // Output monitor and back-pressure
   //##########################################################################

   always @(posedge clk) begin
      if (!reset && access_out && !wait_in) begin      // Delivery this edge
         if (expect_q.size() == 0) begin
            $display("Packet on access_out at %0t ns with none outstanding", $time);
            $display("Test FAILED");
            $fatal(1, "unexpected packet");
         end else begin
            mon_exp = expect_q.pop_front();
            check("loopback packet", packet_out, mon_exp);
         end
      end
   end

   initial begin
      wait_in  = 1'b0;
      bp_state = ~SEED;
      forever begin
         @(negedge clk);
         if (bp_en) begin
            bp_state = lcg(bp_state);
            wait_in  = bp_state[31];         // About half the cycles
         end else begin
            wait_in = 1'b0;
         end
      end
   end

   //##########################################################################
   // Test sequence
   //##########################################################################

   initial begin
      logic [PW-1:0] pkt;
      logic [1:0]    idx;
      int            i;
      int            r;
      int            cnt;
      seed      = SEED;
      bp_en     = 1'b0;
      reset     = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      cfg_m     = DEF_CFG;
      clk_m     = DEF_CLK;
      sent      = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // Reset values
      check("wait_out after reset", PW'(wait_out), PW'(!DEF_CFG[CFG_TX_EN]));
      check("access_out after reset", PW'(access_out), '0);
      check("reg_access_out after reset", PW'(reg_access_out), '0);

      // Tie-off and forwarded clock, sampled mid phase
      check("dut_active", PW'(dut_active), PW'(1'b1));
      #5;
      check("clkout in low phase", PW'(clkout), PW'(1'b0));
      @(posedge clk);
      #5;
      check("clkout in high phase", PW'(clkout), PW'(1'b1));
      @(negedge clk);

      read_reg(REG_CFG);
      read_reg(REG_CLKDIV);
      read_reg(REG_STATUS);

      // Random writes, read back truncated
      for (i = 0; i < 12; i++) begin
         seed = lcg(seed);
         idx  = seed[31:30];
         seed = lcg(seed);
         write_reg(idx, seed);
         read_reg(idx);
      end
      write_reg(REG_STATUS, 32'hffff_ffff);  // Read only
      read_reg(REG_STATUS);

      // Transmitter off, offered packet must not be taken
      write_reg(REG_CFG, 32'(DEF_CFG & ~(CFG_W'(1) << CFG_TX_EN)));
      rand_link(pkt);
      access_in = 1'b1;
      packet_in = pkt;
      for (i = 0; i < WINDOW; i++) begin
         check("wait_out while disabled", PW'(wait_out), PW'(1'b1));
         check("access_out while disabled", PW'(access_out), '0);
         @(negedge clk);
      end
      access_in = 1'b0;
      @(negedge clk);

      // Plain loopback
      write_reg(REG_CFG, 32'(DEF_CFG));
      seed = lcg(seed);
      write_reg(REG_CLKDIV, {30'h0, seed[31:30]});
      for (i = 0; i < N_BASIC; i++) begin
         rand_link(pkt);
         send_link(pkt);
      end
      wait_drain("loopback packets to drain");

      // Loopback under random wait_in, new divider each round
      bp_en = 1'b1;
      for (r = 0; r < 3; r++) begin
         seed = lcg(seed);
         write_reg(REG_CLKDIV, {28'h0, seed[31:28]});
         for (i = 0; i < N_ROUND; i++) begin
            rand_link(pkt);
            send_link(pkt);
         end
         wait_drain("back-pressured packets to drain");
      end
      bp_en = 1'b0;
      cnt   = 0;
      while (wait_in) begin
         if (cnt >= TIMEOUT) timeout_fail("wait_in to settle low");
         @(negedge clk);
         cnt++;
      end

      // Delivered count
      read_reg(REG_STATUS);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire
